// File: filelist.f
common/io_pkg.sv
hw/port_controller.sv
hw/gpio.sv
hw/pwm_led.sv
uart/uart.sv
hw/interrupt_controller.sv
hw/io_top.sv
test/io_top_asserts.sv
test/io_tb.sv

// File: test/io_tb.sv
// I/O subsystem testbench
`timescale 1ns/10ps

module io_tb;

	import io_pkg::*;

	localparam int CLK_HZ = 800000;
	localparam int BAUD   = 100000;    // 8 clocks per bit

	logic               CLK = 1'b0;
	logic               RSTb;
	io_addr_t           address;
	logic [DATA_W-1:0]  data_in;
	logic               mem_wr;
	logic [5:0]         gpio_in;
	logic [DATA_W-1:0]  data_out;
	logic [3:0]         gpio_out;
	logic               led_r;
	logic               led_g;
	logic               led_b;
	logic               uart_tx;
	logic [NUM_IRQ-1:0] irq;
	logic               interrupt;

	// expected register contents
	logic [DATA_W-1:0]  gpio_out_val;
	logic [DATA_W-1:0]  duty_val [3];
	logic [DATA_W-1:0]  enable_val;

	io_top #(.CLOCK_FREQ(CLK_HZ), .BAUD_RATE(BAUD)) u_dut (
		.CLK(CLK), .RSTb(RSTb), .address(address), .data_in(data_in),
		.mem_wr(mem_wr), .gpio_in(gpio_in), .data_out(data_out),
		.gpio_out(gpio_out), .led_r(led_r), .led_g(led_g), .led_b(led_b),
		.uart_tx(uart_tx), .irq(irq), .interrupt(interrupt)
	);

	bind io_top io_top_asserts u_asserts (
		.CLK(CLK), .RSTb(RSTb), .irq(irq), .interrupt(interrupt),
		.uart_tx(uart_tx), .uart_busy(u_uart.busy), .wr_uart(wr_uart),
		.wr_gpio(wr_gpio), .wr_pwm(wr_pwm), .wr_irq(wr_irq)
	);

	always #10 CLK = ~CLK;    // 20 ns period

	function automatic io_addr_t make_addr(logic [3:0] blk, logic [3:0] ofs);
		io_addr_t a;
		a.raw           = '0;
		a.fields.block  = blk;
		a.fields.offset = {8'h00, ofs};
		return a;
	endfunction

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic wait_timeout(string what, int cycles);
		$display("ERROR: gave up waiting for %s after %0d cycles", what, cycles);
		abort_run();
	endtask

	task automatic check_word(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// one cycle with mem_wr high
	task automatic bus_write(io_addr_t a, logic [DATA_W-1:0] d);
		@(posedge CLK);
		address <= a;
		data_in <= d;
		mem_wr  <= 1'b1;
		@(posedge CLK);
		mem_wr  <= 1'b0;
	endtask

	task automatic bus_read(io_addr_t a, output logic [DATA_W-1:0] d);
		@(posedge CLK);
		address <= a;
		mem_wr  <= 1'b0;
		@(posedge CLK);
		@(negedge CLK);    // data_out settled
		d = data_out;
	endtask

	task automatic read_check(io_addr_t a, logic [DATA_W-1:0] exp, string name);
		logic [DATA_W-1:0] d;
		bus_read(a, d);
		check_word(name, d, exp);
	endtask

	task automatic wait_pending(int idx, string what);
		logic [DATA_W-1:0] p;
		int n;
		n = 0;
		bus_read(make_addr(BLK_IRQ, 4'd1), p);
		while (!p[idx] && n < 400) begin
			n++;
			bus_read(make_addr(BLK_IRQ, 4'd1), p);
		end
		if (!p[idx])
			wait_timeout(what, n * 2);
	endtask

	task automatic wait_uart_idle();
		logic [DATA_W-1:0] b;
		int n;
		n = 0;
		bus_read(make_addr(BLK_UART, 4'd1), b);
		while (b[0] && n < 100) begin
			n++;
			bus_read(make_addr(BLK_UART, 4'd1), b);
		end
		if (b[0])
			wait_timeout("UART busy to clear", n * 2);
	endtask

	task automatic test_reset_decode();
		@(negedge CLK);
		check_bit("uart_tx", uart_tx, 1'b1);
		check_bit("led_r", led_r, 1'b0);
		check_bit("led_g", led_g, 1'b0);
		check_bit("led_b", led_b, 1'b0);
		check_bit("interrupt", interrupt, 1'b0);
		check_word("gpio_out", DATA_W'(gpio_out), '0);
		check_word("irq", DATA_W'(irq), '0);
		check_word("data_out", data_out, '0);
		// an unmapped write must leave every mapped register at zero
		bus_write(make_addr(4'h9, 4'd0), 16'hffff);
		// pending must be read before the first PWM wrap
		read_check(make_addr(BLK_IRQ, 4'd1), '0, "irq pending");
		read_check(make_addr(BLK_IRQ, 4'd0), '0, "irq enable");
		read_check(make_addr(BLK_GPIO, 4'd0), '0, "gpio out reg");
		read_check(make_addr(BLK_GPIO, 4'd1), '0, "gpio in reg");
		for (int i = 0; i < 3; i++)
			read_check(make_addr(BLK_PWM, 4'(i)), '0, "pwm duty");
		read_check(make_addr(BLK_UART, 4'd1), '0, "uart busy");
		read_check(make_addr(4'h5, 4'd0), '0, "unmapped block 5");
		read_check(make_addr(4'h9, 4'd0), '0, "unmapped block 9");

		gpio_out_val = DATA_W'($urandom);
		bus_write(make_addr(BLK_GPIO, 4'd0), gpio_out_val);
		gpio_out_val = gpio_out_val & 16'h000f;
		for (int i = 0; i < 3; i++) begin
			duty_val[i] = DATA_W'($urandom);
			bus_write(make_addr(BLK_PWM, 4'(i)), duty_val[i]);
			duty_val[i] = duty_val[i] & 16'h00ff;
		end
		enable_val = DATA_W'($urandom);
		bus_write(make_addr(BLK_IRQ, 4'd0), enable_val);
		enable_val = enable_val & 16'h000f;

		read_check(make_addr(BLK_GPIO, 4'd0), gpio_out_val, "gpio out reg");
		check_word("gpio_out", DATA_W'(gpio_out), gpio_out_val);
		for (int i = 0; i < 3; i++)
			read_check(make_addr(BLK_PWM, 4'(i)), duty_val[i], "pwm duty");
		read_check(make_addr(BLK_IRQ, 4'd0), enable_val, "irq enable");
	endtask

	// one new address per cycle
	task automatic test_pipelined_reads();
		io_addr_t          addrs [6];
		logic [DATA_W-1:0] exp [6];
		addrs[0] = make_addr(BLK_GPIO, 4'd0);
		exp[0]   = gpio_out_val;
		addrs[1] = make_addr(BLK_PWM, 4'd0);
		exp[1]   = duty_val[0];
		addrs[2] = make_addr(4'hc, 4'd0);
		exp[2]   = '0;
		addrs[3] = make_addr(BLK_IRQ, 4'd0);
		exp[3]   = enable_val;
		addrs[4] = make_addr(BLK_PWM, 4'd2);
		exp[4]   = duty_val[2];
		addrs[5] = make_addr(BLK_GPIO, 4'd0);
		exp[5]   = gpio_out_val;
		@(posedge CLK);
		address <= addrs[0];
		mem_wr  <= 1'b0;
		for (int i = 1; i <= 6; i++) begin
			@(posedge CLK);
			if (i < 6)
				address <= addrs[i];
			@(negedge CLK);
			check_word("data_out pipelined", data_out, exp[i-1]);
		end
	endtask

	task automatic test_gpio_input();
		logic [5:0] v;
		for (int i = 0; i < 6; i++) begin
			v = 6'($urandom);
			@(posedge CLK);
			gpio_in <= v;
			repeat (3) @(posedge CLK);    // two sync flops plus margin
			read_check(make_addr(BLK_GPIO, 4'd1), DATA_W'(v), "gpio in reg");
		end
	endtask

	task automatic test_pwm_duty();
		logic [7:0] mid;
		int         on_g;
		int         on_b;
		mid = 8'($urandom_range(254, 1));
		bus_write(make_addr(BLK_PWM, 4'd0), 16'h0000);
		bus_write(make_addr(BLK_PWM, 4'd1), 16'h00ff);
		bus_write(make_addr(BLK_PWM, 4'd2), DATA_W'(mid));
		repeat (2) @(posedge CLK);
		on_g = 0;
		on_b = 0;
		for (int c = 0; c < 256; c++) begin    // one full PWM period
			@(negedge CLK);
			check_bit("led_r at duty 0", led_r, 1'b0);
			if (led_g)
				on_g++;
			if (led_b)
				on_b++;
		end
		check_word("led_g on count", DATA_W'(on_g), 16'd255);
		check_word("led_b on count", DATA_W'(on_b), DATA_W'(mid));
	endtask

	task automatic test_uart_frame();
		logic [7:0] tx_byte;
		logic [9:0] frame;
		int         n;
		tx_byte = 8'($urandom);
		bus_write(make_addr(BLK_UART, 4'd0), DATA_W'(tx_byte));
		address <= make_addr(BLK_UART, 4'd1);    // poll busy during the frame
		n = 0;
		@(negedge CLK);
		while (uart_tx !== 1'b0 && n < 4) begin
			n++;
			@(negedge CLK);
		end
		if (uart_tx !== 1'b0)
			wait_timeout("UART start bit", n);
		frame = '0;
		for (int t = 0; t < 80; t++) begin
			if (t % 8 == 4)
				frame[t/8] = uart_tx;    // middle of each bit
			if (t >= 1 && t != 22)
				check_word("uart busy", data_out, 16'h0001);
			@(posedge CLK);
			if (t == 20) begin    // second write, must be dropped
				address <= make_addr(BLK_UART, 4'd0);
				data_in <= DATA_W'(~tx_byte);
				mem_wr  <= 1'b1;
			end else if (t == 21) begin
				address <= make_addr(BLK_UART, 4'd1);
				mem_wr  <= 1'b0;
			end
			@(negedge CLK);
		end
		check_bit("start bit", frame[0], 1'b0);
		check_byte("uart byte", frame[8:1], tx_byte);
		check_bit("stop bit", frame[9], 1'b1);
		wait_uart_idle();
		for (int c = 0; c < 20; c++) begin
			@(negedge CLK);
			check_bit("uart_tx after frame", uart_tx, 1'b1);
		end
	endtask

	task automatic test_interrupts();
		logic [DATA_W-1:0] pend;
		logic [DATA_W-1:0] pend_exp;
		logic [DATA_W-1:0] en;
		@(posedge CLK);
		gpio_in <= '0;
		repeat (4) @(posedge CLK);
		en = '0;
		en[IRQ_GPIO0]     = 1'b1;
		en[IRQ_UART_DONE] = 1'b1;
		pend_exp = '0;
		pend_exp[IRQ_GPIO0]     = 1'b1;
		pend_exp[IRQ_UART_DONE] = 1'b1;
		bus_write(make_addr(BLK_IRQ, 4'd0), en);
		bus_write(make_addr(BLK_IRQ, 4'd1), 16'h000f);    // start clean
		@(posedge CLK);
		gpio_in <= 6'b000001;
		wait_pending(IRQ_GPIO0, "GPIO0 pending bit");
		bus_write(make_addr(BLK_UART, 4'd0), DATA_W'($urandom));
		wait_uart_idle();
		wait_pending(IRQ_UART_DONE, "UART done pending bit");
		bus_read(make_addr(BLK_IRQ, 4'd1), pend);
		check_word("pending", pend & 16'h0007, pend_exp);
		@(negedge CLK);
		check_word("irq", DATA_W'(irq), pend_exp & en);
		check_bit("interrupt", interrupt, |(pend_exp & en));

		bus_write(make_addr(BLK_IRQ, 4'd1), 16'h0007);
		bus_read(make_addr(BLK_IRQ, 4'd1), pend);
		check_word("pending after clear", pend & 16'h0007, '0);
		@(negedge CLK);
		check_word("irq after clear", DATA_W'(irq), '0);
		check_bit("interrupt after clear", interrupt, 1'b0);

		// wrap source stays masked
		bus_write(make_addr(BLK_IRQ, 4'd1), 16'h0008);
		wait_pending(IRQ_PWM_WRAP, "PWM wrap pending bit");
		@(negedge CLK);
		check_word("irq with wrap pending", DATA_W'(irq), '0);
		check_bit("interrupt with wrap pending", interrupt, 1'b0);
	endtask

	initial begin
		RSTb     = 1'b0;
		address  = '0;
		data_in  = '0;
		mem_wr   = 1'b0;
		gpio_in  = '0;
		void'($urandom(32'h6d084bb0));
		repeat (16) @(posedge CLK);
		RSTb <= 1'b1;

		test_reset_decode();
		test_pipelined_reads();
		test_gpio_input();
		test_pwm_duty();
		test_uart_frame();
		test_interrupts();

		repeat (4) @(posedge CLK);
		if (u_dut.u_asserts.fail_cnt == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("ERROR: %0d assertion failures", u_dut.u_asserts.fail_cnt);
			$display("TEST RESULT: FAIL");
			$fatal(1, "assertions failed during the run");
		end
	end

endmodule

// File: test/io_top_asserts.sv
// I/O subsystem assertions
`timescale 1ns/10ps

module io_top_asserts (
	input logic                        CLK,
	input logic                        RSTb,
	input logic [io_pkg::NUM_IRQ-1:0]  irq,
	input logic                        interrupt,
	input logic                        uart_tx,
	input logic                        uart_busy,
	input logic                        wr_uart,
	input logic                        wr_gpio,
	input logic                        wr_pwm,
	input logic                        wr_irq
);

	int fail_cnt = 0;    // polled by the testbench at the end

	summary_a: assert property (@(posedge CLK) disable iff (!RSTb)
		interrupt == (irq != '0))
		else begin
			fail_cnt++;
			$error("interrupt does not match the OR of irq");
		end

	// idle line stays high
	tx_idle_a: assert property (@(posedge CLK) disable iff (!RSTb)
		!uart_busy |-> uart_tx)
		else begin
			fail_cnt++;
			$error("uart_tx low while the UART is idle");
		end

	strobe_a: assert property (@(posedge CLK) disable iff (!RSTb)
		$onehot0({wr_uart, wr_gpio, wr_pwm, wr_irq}))
		else begin
			fail_cnt++;
			$error("more than one block write strobe active");
		end

endmodule

// File: hw/io_top.sv
// Memory mapped I/O subsystem
`timescale 1ns/10ps

module io_top #(
	parameter int CLOCK_FREQ = 10000000,
	parameter int BAUD_RATE  = 115200
) (
	input  logic                        CLK,
	input  logic                        RSTb,
	input  io_pkg::io_addr_t            address,
	input  logic [io_pkg::DATA_W-1:0]   data_in,
	input  logic                        mem_wr,
	input  logic [5:0]                  gpio_in,
	output logic [io_pkg::DATA_W-1:0]   data_out,
	output logic [3:0]                  gpio_out,
	output logic                        led_r,
	output logic                        led_g,
	output logic                        led_b,
	output logic                        uart_tx,
	output logic [io_pkg::NUM_IRQ-1:0]  irq,
	output logic                        interrupt
);

	import io_pkg::*;

	logic [3:0]         reg_ofs;    // register select within a block
	logic               wr_uart, wr_gpio, wr_pwm, wr_irq;
	logic [DATA_W-1:0]  rdata_uart, rdata_gpio, rdata_pwm, rdata_irq;
	logic [1:0]         gpio_rise;
	logic               uart_done;
	logic               pwm_wrap;
	logic [NUM_IRQ-1:0] src;

	assign reg_ofs = address.fields.offset[3:0];

	// interrupt source order
	assign src[IRQ_GPIO0]     = gpio_rise[0];
	assign src[IRQ_GPIO1]     = gpio_rise[1];
	assign src[IRQ_UART_DONE] = uart_done;
	assign src[IRQ_PWM_WRAP]  = pwm_wrap;

	port_controller u_port_controller (
		.CLK(CLK), .RSTb(RSTb), .address(address), .mem_wr(mem_wr),
		.rdata_uart(rdata_uart), .rdata_gpio(rdata_gpio),
		.rdata_pwm(rdata_pwm), .rdata_irq(rdata_irq), .data_out(data_out),
		.wr_uart(wr_uart), .wr_gpio(wr_gpio), .wr_pwm(wr_pwm), .wr_irq(wr_irq)
	);

	gpio u_gpio (
		.CLK(CLK), .RSTb(RSTb), .offset(reg_ofs), .data_in(data_in), .wr(wr_gpio),
		.gpio_in(gpio_in), .rdata(rdata_gpio), .gpio_out(gpio_out), .rise(gpio_rise)
	);

	pwm_led u_pwm_led (
		.CLK(CLK), .RSTb(RSTb), .offset(reg_ofs), .data_in(data_in), .wr(wr_pwm),
		.rdata(rdata_pwm), .led_r(led_r), .led_g(led_g), .led_b(led_b), .wrap(pwm_wrap)
	);

	uart #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) u_uart (
		.CLK(CLK), .RSTb(RSTb), .offset(reg_ofs), .data_in(data_in), .wr(wr_uart),
		.rdata(rdata_uart), .uart_tx(uart_tx), .done(uart_done)
	);

	interrupt_controller u_interrupt_controller (
		.CLK(CLK), .RSTb(RSTb), .offset(reg_ofs), .data_in(data_in), .wr(wr_irq),
		.src(src), .rdata(rdata_irq), .irq(irq), .interrupt(interrupt)
	);

endmodule

// File: hw/interrupt_controller.sv
// Interrupt controller
`timescale 1ns/10ps

module interrupt_controller (
	input  logic                        CLK,
	input  logic                        RSTb,
	input  logic [3:0]                  offset,
	input  logic [io_pkg::DATA_W-1:0]   data_in,
	input  logic                        wr,
	input  logic [io_pkg::NUM_IRQ-1:0]  src,
	output logic [io_pkg::DATA_W-1:0]   rdata,
	output logic [io_pkg::NUM_IRQ-1:0]  irq,
	output logic                        interrupt
);

	import io_pkg::*;

	logic [NUM_IRQ-1:0] enable;
	logic [NUM_IRQ-1:0] pending;
	logic [NUM_IRQ-1:0] clr;    // write-one-to-clear mask

	assign clr = (wr && offset == 4'd1) ? data_in[NUM_IRQ-1:0] : '0;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			enable <= '0;
		end else if (wr && offset == 4'd0) begin
			enable <= data_in[NUM_IRQ-1:0];
		end
	end

	// a source pulse beats a clear in the same cycle
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~clr) | src;
		end
	end

	assign irq       = pending & enable;
	assign interrupt = |irq;

	always_comb begin
		rdata = '0;
		case (offset)
			4'd0: rdata[NUM_IRQ-1:0] = enable;
			4'd1: rdata[NUM_IRQ-1:0] = pending;
			default: rdata = '0;
		endcase
	end

endmodule

// File: uart/uart.sv
// UART transmitter, 8N1
`timescale 1ns/10ps

module uart #(
	parameter int CLOCK_FREQ = 10000000,
	parameter int BAUD_RATE  = 115200
) (
	input  logic                       CLK,
	input  logic                       RSTb,
	input  logic [3:0]                 offset,
	input  logic [io_pkg::DATA_W-1:0]  data_in,
	input  logic                       wr,
	output logic [io_pkg::DATA_W-1:0]  rdata,
	output logic                       uart_tx,
	output logic                       done
);

	import io_pkg::*;

	localparam int DIV   = CLOCK_FREQ / BAUD_RATE;    // clocks per bit
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic             busy;
	logic [CNT_W-1:0] baud_cnt;
	logic [3:0]       bit_cnt;    // 0 start, 1..8 data, 9 stop
	logic [9:0]       shreg;      // bit 0 is on the line
	logic             start;
	logic             bit_end;

	assign start   = wr && (offset == 4'd0) && !busy;    // writes while busy dropped
	assign bit_end = (baud_cnt == CNT_W'(DIV - 1));

	// control state
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			busy     <= 1'b0;
			done     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy     <= 1'b1;
				baud_cnt <= '0;
				bit_cnt  <= '0;
			end else if (busy) begin
				if (bit_end) begin
					baud_cnt <= '0;
					if (bit_cnt == 4'd9) begin
						busy <= 1'b0;    // stop bit over
						done <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 4'd1;
					end
				end else begin
					baud_cnt <= baud_cnt + CNT_W'(1);
				end
			end
		end
	end

	// frame shifter, stop bit on top and start bit at the bottom
	always_ff @(posedge CLK) begin
		if (start)
			shreg <= {1'b1, data_in[7:0], 1'b0};
		else if (busy && bit_end)
			shreg <= {1'b1, shreg[9:1]};    // LSB first
	end

	assign uart_tx = busy ? shreg[0] : 1'b1;    // line idles high

	assign rdata = (offset == 4'd1) ? {{(DATA_W-1){1'b0}}, busy} : '0;

endmodule

// File: hw/pwm_led.sv
// RGB LED PWM driver
`timescale 1ns/10ps

module pwm_led (
	input  logic                       CLK,
	input  logic                       RSTb,
	input  logic [3:0]                 offset,
	input  logic [io_pkg::DATA_W-1:0]  data_in,
	input  logic                       wr,
	output logic [io_pkg::DATA_W-1:0]  rdata,
	output logic                       led_r,
	output logic                       led_g,
	output logic                       led_b,
	output logic                       wrap
);

	import io_pkg::*;

	logic [7:0] duty_r;
	logic [7:0] duty_g;
	logic [7:0] duty_b;
	logic [7:0] cnt;    // free running period counter

	// duty registers, must read zero after reset
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			duty_r <= '0;
			duty_g <= '0;
			duty_b <= '0;
		end else if (wr) begin
			case (offset)
				4'd0: duty_r <= data_in[7:0];
				4'd1: duty_g <= data_in[7:0];
				4'd2: duty_b <= data_in[7:0];
				default: ;
			endcase
		end
	end

	// compare uses the counter before its update
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cnt   <= '0;
			led_r <= 1'b0;
			led_g <= 1'b0;
			led_b <= 1'b0;
			wrap  <= 1'b0;
		end else begin
			cnt   <= cnt + 8'd1;
			led_r <= (cnt < duty_r);    // duty 0 never lights
			led_g <= (cnt < duty_g);
			led_b <= (cnt < duty_b);
			wrap  <= (cnt == 8'hff);    // high while cnt is back at 0
		end
	end

	always_comb begin
		case (offset)
			4'd0: rdata = {{(DATA_W-8){1'b0}}, duty_r};
			4'd1: rdata = {{(DATA_W-8){1'b0}}, duty_g};
			4'd2: rdata = {{(DATA_W-8){1'b0}}, duty_b};
			default: rdata = '0;
		endcase
	end

endmodule

// File: hw/gpio.sv
// GPIO port
`timescale 1ns/10ps

module gpio (
	input  logic                       CLK,
	input  logic                       RSTb,
	input  logic [3:0]                 offset,
	input  logic [io_pkg::DATA_W-1:0]  data_in,
	input  logic                       wr,
	input  logic [5:0]                 gpio_in,
	output logic [io_pkg::DATA_W-1:0]  rdata,
	output logic [3:0]                 gpio_out,
	output logic [1:0]                 rise
);

	import io_pkg::*;

	logic [5:0] in_meta;    // first sync stage
	logic [5:0] in_sync;    // second stage, the readable in register
	logic [1:0] in_prev;    // last value of inputs 0 and 1

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			gpio_out <= '0;
			in_meta  <= '0;
			in_sync  <= '0;
			in_prev  <= '0;
			rise     <= '0;
		end else begin
			if (wr && offset == 4'd0)
				gpio_out <= data_in[3:0];
			in_meta <= gpio_in;
			in_sync <= in_meta;
			in_prev <= in_sync[1:0];
			rise    <= in_sync[1:0] & ~in_prev;    // one cycle per edge
		end
	end

	always_comb begin
		rdata = '0;
		case (offset)
			4'd0: rdata[3:0] = gpio_out;
			4'd1: rdata[5:0] = in_sync;
			default: rdata = '0;
		endcase
	end

endmodule

// File: hw/port_controller.sv
// I/O port controller
`timescale 1ns/10ps

module port_controller (
	input  logic                       CLK,
	input  logic                       RSTb,
	input  io_pkg::io_addr_t           address,
	input  logic                       mem_wr,
	input  logic [io_pkg::DATA_W-1:0]  rdata_uart,
	input  logic [io_pkg::DATA_W-1:0]  rdata_gpio,
	input  logic [io_pkg::DATA_W-1:0]  rdata_pwm,
	input  logic [io_pkg::DATA_W-1:0]  rdata_irq,
	output logic [io_pkg::DATA_W-1:0]  data_out,
	output logic                       wr_uart,
	output logic                       wr_gpio,
	output logic                       wr_pwm,
	output logic                       wr_irq
);

	import io_pkg::*;

	logic [DATA_W-1:0] rd_next;    // read word of the addressed block

	// decode the block field into a strobe and a read source
	always_comb begin
		wr_uart = 1'b0;
		wr_gpio = 1'b0;
		wr_pwm  = 1'b0;
		wr_irq  = 1'b0;
		rd_next = '0;    // unmapped blocks read zero

		case (address.fields.block)
			BLK_UART: begin
				wr_uart = mem_wr;
				rd_next = rdata_uart;
			end
			BLK_GPIO: begin
				wr_gpio = mem_wr;
				rd_next = rdata_gpio;
			end
			BLK_PWM: begin
				wr_pwm  = mem_wr;
				rd_next = rdata_pwm;
			end
			BLK_IRQ: begin
				wr_irq  = mem_wr;
				rd_next = rdata_irq;
			end
			default: begin
				rd_next = '0;    // writes ignored as well
			end
		endcase
	end

	// result stage, one cycle read latency
	// a new address every cycle gives one read word per cycle
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			data_out <= '0;
		end else begin
			data_out <= rd_next;
		end
	end

endmodule

// File: common/io_pkg.sv
// I/O subsystem shared definitions
package io_pkg;

	// bus widths, fixed by the CPU word
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	localparam int BLK_W = 4;                 // top nibble selects the block
	localparam int OFS_W = ADDR_W - BLK_W;    // 4 KB per block

	// block codes
	localparam logic [BLK_W-1:0] BLK_UART = 4'h0;
	localparam logic [BLK_W-1:0] BLK_GPIO = 4'h1;
	localparam logic [BLK_W-1:0] BLK_PWM  = 4'h2;
	localparam logic [BLK_W-1:0] BLK_IRQ  = 4'h7;

	// interrupt sources, bit positions in the pending register
	localparam int NUM_IRQ       = 4;
	localparam int IRQ_GPIO0     = 0;
	localparam int IRQ_GPIO1     = 1;
	localparam int IRQ_UART_DONE = 2;
	localparam int IRQ_PWM_WRAP  = 3;

	typedef struct packed {
		logic [BLK_W-1:0] block;
		logic [OFS_W-1:0] offset;
	} io_addr_fields_t;

	// one address word, seen whole or split into block and offset
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		io_addr_fields_t   fields;
	} io_addr_t;

endpackage
